//--- lsu_pkg.sv
// shared address map, sizes and types for the load/store and MMIO subsystem
// every design file refers to these by scoped name

package lsu_pkg;

    // ==============================
    // widths and data memory
    // ==============================
    localparam int xlen = 32;
    localparam int lane_count = 4;

    localparam logic [xlen-1:0] dmem_base = 32'h0001_0000;
    localparam int unsigned dmem_bytes = 4096;
    localparam int dmem_words = dmem_bytes / lane_count;
    localparam int dmem_index_w = $clog2(dmem_words);

    // ==============================
    // io address map
    // ==============================
    localparam logic [xlen-1:0] cycle_addr = 32'h0000_ff00;
    // store sends low byte, load returns busy in bit 0
    localparam logic [xlen-1:0] uart_tx_addr = 32'h0000_ff04;
    localparam logic [xlen-1:0] gpi_addr = 32'h0000_ff0c;
    localparam logic [xlen-1:0] gpo_addr = 32'h0000_ff10;

    localparam int gpio_w = 4;

    // clocks per uart bit, small for simulation
    localparam int baud_div = 8;

    // ==============================
    // types
    // ==============================
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } access_size_t;

    typedef enum logic [2:0] {
        region_none  = 3'd0,
        region_dmem  = 3'd1,
        region_cycle = 3'd2,
        region_uart  = 3'd3,
        region_gpi   = 3'd4,
        region_gpo   = 3'd5
    } region_t;

endpackage

//--- lsu_request_decode.sv
// combinational request decode: region, store lane steering and byte enables
// feeds the data RAM, GPO, UART start and the load pipeline register
`timescale 1ns/1ns

module lsu_request_decode (
    input  logic                              req_valid,
    input  logic                              req_is_store,
    input  lsu_pkg::access_size_t             req_size,
    input  logic                              req_unsigned,
    input  logic [lsu_pkg::xlen-1:0]          req_addr,
    input  logic [lsu_pkg::xlen-1:0]          req_wdata,
    input  logic                              busy,
    output logic [lsu_pkg::lane_count-1:0]    ram_we,
    output logic [lsu_pkg::dmem_index_w-1:0]  ram_index,
    output logic [lsu_pkg::xlen-1:0]          ram_wdata,
    output logic                              gpo_we,
    output logic [lsu_pkg::gpio_w-1:0]        gpo_wdata,
    output logic                              tx_start,
    output logic [7:0]                        tx_byte,
    output logic                              load_valid,
    output lsu_pkg::region_t                  load_region,
    output lsu_pkg::access_size_t             load_size,
    output logic                              load_unsigned,
    output logic [1:0]                        load_offset
);

    logic [lsu_pkg::xlen-1:0] dmem_offset;
    logic                     is_word;
    logic                     do_store;
    logic                     misaligned;
    lsu_pkg::region_t         region;
    logic [lsu_pkg::lane_count-1:0] lane_en;

    // below-base addresses wrap to a large offset, so one compare covers both bounds
    assign dmem_offset = req_addr - lsu_pkg::dmem_base;
    assign is_word = (req_size == lsu_pkg::size_word);
    assign do_store = req_valid && req_is_store;

    always_comb begin
        region = lsu_pkg::region_none;
        if (dmem_offset < lsu_pkg::dmem_bytes) begin
            region = lsu_pkg::region_dmem;
        end else if (is_word) begin
            if (req_addr == lsu_pkg::cycle_addr) region = lsu_pkg::region_cycle;
            if (req_addr == lsu_pkg::uart_tx_addr) region = lsu_pkg::region_uart;
            if (req_addr == lsu_pkg::gpi_addr) region = lsu_pkg::region_gpi;
            if (req_addr == lsu_pkg::gpo_addr) region = lsu_pkg::region_gpo;
        end
    end

    // lane steering
    always_comb begin
        case (req_size)
            lsu_pkg::size_byte: begin
                lane_en = 4'b0001 << req_addr[1:0];
                ram_wdata = {4{req_wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
                lane_en = req_addr[1] ? 4'b1100 : 4'b0011;
                ram_wdata = {2{req_wdata[15:0]}};
            end
            default: begin
                lane_en = 4'b1111;
                ram_wdata = req_wdata;
            end
        endcase
    end

    assign ram_we = (do_store && region == lsu_pkg::region_dmem) ? lane_en : '0;
    assign ram_index = dmem_offset[lsu_pkg::dmem_index_w+1:2];

    assign gpo_we = do_store && (region == lsu_pkg::region_gpo);
    assign gpo_wdata = req_wdata[lsu_pkg::gpio_w-1:0];

    // a store while the transmitter is busy is dropped
    assign tx_start = do_store && (region == lsu_pkg::region_uart) && !busy;
    assign tx_byte = req_wdata[7:0];

    assign load_valid = req_valid && !req_is_store;
    assign load_region = region;
    assign load_size = req_size;
    assign load_unsigned = req_unsigned;
    assign load_offset = req_addr[1:0];

    assign misaligned = (req_size == lsu_pkg::size_half && req_addr[0]) ||
                        (is_word && req_addr[1:0] != 2'b00);

    always_comb begin
        if (req_valid) begin
            assert final (!misaligned)
            else $error("misaligned access, addr %h size %0d", req_addr, req_size);
        end
    end

endmodule

//--- data_ram.sv
// four byte-lane data RAM, one write enable per lane
// read is registered so data lines up with the one-cycle load response
`timescale 1ns/1ns

module data_ram (
    input  logic                              clk,
    input  logic [lsu_pkg::lane_count-1:0]    ram_we,
    input  logic [lsu_pkg::dmem_index_w-1:0]  ram_index,
    input  logic [lsu_pkg::xlen-1:0]          ram_wdata,
    output logic [lsu_pkg::xlen-1:0]          ram_rdata
);

    // ==============================
    // byte lanes
    // ==============================
    for (genvar lane = 0; lane < lsu_pkg::lane_count; lane++) begin : g_lane
        logic [7:0] mem [0:lsu_pkg::dmem_words-1];

        always_ff @(posedge clk) begin
            if (ram_we[lane]) begin
                mem[ram_index] <= ram_wdata[lane*8 +: 8];
            end
            ram_rdata[lane*8 +: 8] <= mem[ram_index];
        end
    end

endmodule

//--- lsu_load_align.sv
// load pipeline register and result formatting
// selects the source by region, then extracts and extends lanes by size and offset
`timescale 1ns/1ns

module lsu_load_align (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_valid,
    input  lsu_pkg::region_t                load_region,
    input  lsu_pkg::access_size_t           load_size,
    input  logic                            load_unsigned,
    input  logic [1:0]                      load_offset,
    input  logic [lsu_pkg::xlen-1:0]        ram_rdata,
    input  logic [lsu_pkg::xlen-1:0]        cycle_count,
    input  logic                            busy,
    input  logic [lsu_pkg::gpio_w-1:0]      gpi_value,
    input  logic [lsu_pkg::gpio_w-1:0]      gpo_value,
    output logic                            rsp_valid,
    output logic [lsu_pkg::xlen-1:0]        rsp_rdata
);

    logic                          valid_q;
    lsu_pkg::region_t              region_q;
    lsu_pkg::access_size_t         size_q;
    logic                          unsigned_q;
    logic [1:0]                    offset_q;
    logic [lsu_pkg::xlen-1:0]      cycle_q;
    logic                          busy_q;
    logic [lsu_pkg::gpio_w-1:0]    gpi_q;
    logic [lsu_pkg::gpio_w-1:0]    gpo_q;
    logic [7:0]                    lane_byte;
    logic [15:0]                   lane_half;
    logic [lsu_pkg::xlen-1:0]      mem_value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_valid;
        end
    end

    // io values taken in the request cycle
    always_ff @(posedge clk) begin
        region_q <= load_region;
        size_q <= load_size;
        unsigned_q <= load_unsigned;
        offset_q <= load_offset;
        cycle_q <= cycle_count;
        busy_q <= busy;
        gpi_q <= gpi_value;
        gpo_q <= gpo_value;
    end

    // ==============================
    // lane extraction
    // ==============================
    assign lane_byte = ram_rdata[{offset_q, 3'b000} +: 8];
    assign lane_half = offset_q[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (size_q)
            lsu_pkg::size_byte: mem_value = {{24{lane_byte[7] & ~unsigned_q}}, lane_byte};
            lsu_pkg::size_half: mem_value = {{16{lane_half[15] & ~unsigned_q}}, lane_half};
            default: mem_value = ram_rdata;
        endcase
    end

    always_comb begin
        case (region_q)
            lsu_pkg::region_dmem:  rsp_rdata = mem_value;
            lsu_pkg::region_cycle: rsp_rdata = cycle_q;
            lsu_pkg::region_uart:  rsp_rdata = {31'd0, busy_q};
            lsu_pkg::region_gpi:   rsp_rdata = {{(lsu_pkg::xlen-lsu_pkg::gpio_w){1'b0}}, gpi_q};
            lsu_pkg::region_gpo:   rsp_rdata = {{(lsu_pkg::xlen-lsu_pkg::gpio_w){1'b0}}, gpo_q};
            default:               rsp_rdata = '0;
        endcase
    end

    assign rsp_valid = valid_q;

endmodule

//--- io_regs.sv
// GPI input register, GPO register and free-running cycle counter
`timescale 1ns/1ns

module io_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [lsu_pkg::gpio_w-1:0]    gpi,
    input  logic                          gpo_we,
    input  logic [lsu_pkg::gpio_w-1:0]    gpo_wdata,
    output logic [lsu_pkg::gpio_w-1:0]    gpi_value,
    output logic [lsu_pkg::gpio_w-1:0]    gpo_value,
    output logic [lsu_pkg::xlen-1:0]      cycle_count
);

    // gpi pins sampled every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpi_value <= '0;
        end else begin
            gpi_value <= gpi;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpo_value <= '0;
        end else if (gpo_we) begin
            gpo_value <= gpo_wdata;
        end
    end

    // wraps silently
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

endmodule

//--- baud_timer.sv
// bit-period timer for the UART transmitter
// tick pulses once per baud_div cycles while run is high
`timescale 1ns/1ns

module baud_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    output logic tick
);

    logic [$clog2(lsu_pkg::baud_div)-1:0] count;

    assign tick = run && (count == ($clog2(lsu_pkg::baud_div))'(lsu_pkg::baud_div - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run || tick) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- uart_tx_fsm.sv
// UART transmit FSM: start bit, eight data bits LSB first, stop bit
// advances on the baud tick, busy outside idle
`timescale 1ns/1ns

module uart_tx_fsm (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    input  logic       tick,
    output logic       run,
    output logic       busy,
    output logic       uart_tx
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } tx_state_t;

    tx_state_t  state;
    logic [7:0] shift;
    logic [2:0] bit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            bit_idx <= 3'd0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    if (tx_start) begin
                        state <= st_start;
                        uart_tx <= 1'b0;
                    end
                end
                st_start: begin
                    if (tick) begin
                        state <= st_data;
                        bit_idx <= 3'd0;
                        uart_tx <= shift[0];
                    end
                end
                st_data: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                            uart_tx <= 1'b1;
                        end else begin
                            uart_tx <= shift[1];
                        end
                    end
                end
                default: begin
                    if (tick) state <= st_idle;
                end
            endcase
        end
    end

    // frame data, loaded on start and shifted per data bit
    always_ff @(posedge clk) begin
        if (state == st_idle && tx_start) begin
            shift <= tx_byte;
        end else if (state == st_data && tick) begin
            shift <= shift >> 1;
        end
    end

    assign busy = (state != st_idle);
    assign run = busy;

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_idle) |-> uart_tx
    ) else $error("uart_tx low while transmitter idle");

endmodule

//--- mmio_top.sv
// load/store and memory-mapped io subsystem top
// request in, one-cycle load response out, plus GPO pins and the UART line
`timescale 1ns/1ns

module mmio_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic                          req_is_store,
    input  lsu_pkg::access_size_t         req_size,
    input  logic                          req_unsigned,
    input  logic [lsu_pkg::xlen-1:0]      req_addr,
    input  logic [lsu_pkg::xlen-1:0]      req_wdata,
    input  logic [lsu_pkg::gpio_w-1:0]    gpi,
    output logic                          rsp_valid,
    output logic [lsu_pkg::xlen-1:0]      rsp_rdata,
    output logic [lsu_pkg::gpio_w-1:0]    gpo,
    output logic                          uart_tx
);

    logic [lsu_pkg::lane_count-1:0]   ram_we;
    logic [lsu_pkg::dmem_index_w-1:0] ram_index;
    logic [lsu_pkg::xlen-1:0]         ram_wdata;
    logic [lsu_pkg::xlen-1:0]         ram_rdata;
    logic                             gpo_we;
    logic [lsu_pkg::gpio_w-1:0]       gpo_wdata;
    logic [lsu_pkg::gpio_w-1:0]       gpi_value;
    logic [lsu_pkg::xlen-1:0]         cycle_count;
    logic                             tx_start;
    logic [7:0]                       tx_byte;
    logic                             busy;
    logic                             run;
    logic                             tick;
    logic                             load_valid;
    lsu_pkg::region_t                 load_region;
    lsu_pkg::access_size_t            load_size;
    logic                             load_unsigned;
    logic [1:0]                       load_offset;

    // ==============================
    // request side
    // ==============================
    lsu_request_decode u_decode (
        .req_valid(req_valid), .req_is_store(req_is_store), .req_size(req_size),
        .req_unsigned(req_unsigned), .req_addr(req_addr), .req_wdata(req_wdata),
        .busy(busy), .ram_we(ram_we), .ram_index(ram_index), .ram_wdata(ram_wdata),
        .gpo_we(gpo_we), .gpo_wdata(gpo_wdata), .tx_start(tx_start), .tx_byte(tx_byte),
        .load_valid(load_valid), .load_region(load_region), .load_size(load_size),
        .load_unsigned(load_unsigned), .load_offset(load_offset)
    );

    data_ram u_ram (
        .clk(clk), .ram_we(ram_we), .ram_index(ram_index),
        .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
    );

    io_regs u_io (
        .clk(clk), .rst_n(rst_n), .gpi(gpi), .gpo_we(gpo_we), .gpo_wdata(gpo_wdata),
        .gpi_value(gpi_value), .gpo_value(gpo), .cycle_count(cycle_count)
    );

    // ==============================
    // uart and load response
    // ==============================
    baud_timer u_baud (
        .clk(clk), .rst_n(rst_n), .run(run), .tick(tick)
    );

    uart_tx_fsm u_uart (
        .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
        .tick(tick), .run(run), .busy(busy), .uart_tx(uart_tx)
    );

    lsu_load_align u_align (
        .clk(clk), .rst_n(rst_n), .load_valid(load_valid), .load_region(load_region),
        .load_size(load_size), .load_unsigned(load_unsigned), .load_offset(load_offset),
        .ram_rdata(ram_rdata), .cycle_count(cycle_count), .busy(busy),
        .gpi_value(gpi_value), .gpo_value(gpo),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata)
    );

endmodule

//--- tb_uart_monitor.sv
// serial line checker for the UART transmitter
// samples each bit mid-period, checks start, data and stop bits and the idle gap after
`timescale 1ns/1ns

module tb_uart_monitor (
    input  logic       clk,
    input  logic       uart_tx,
    input  logic [7:0] expect_byte,
    output int         frames,
    output logic       error
);

    localparam int bit_cycles = lsu_pkg::baud_div;

    initial begin : decode
        logic [7:0] got;
        frames = 0;
        error = 1'b0;
        got = '0;
        forever begin
            @(negedge clk);
            if (uart_tx === 1'b0) begin
                // middle of the start bit
                repeat (bit_cycles / 2 - 1) @(negedge clk);
                assert (uart_tx === 1'b0)
                else begin
                    $display("Fail %0t uart_tx start bit expected 0 got %b", $time, uart_tx);
                    error = 1'b1;
                end
                // lsb first
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    got[i] = uart_tx;
                end
                assert (got === expect_byte)
                else begin
                    $display("Fail %0t uart_tx data expected %h got %h", $time, expect_byte, got);
                    error = 1'b1;
                end
                repeat (bit_cycles) @(negedge clk);
                assert (uart_tx === 1'b1)
                else begin
                    $display("Fail %0t uart_tx stop bit expected 1 got %b", $time, uart_tx);
                    error = 1'b1;
                end
                // rest of the stop bit, then one frame time of idle line
                for (int i = 0; i < bit_cycles / 2 + 10 * bit_cycles; i++) begin
                    @(negedge clk);
                    assert (uart_tx === 1'b1)
                    else begin
                        $display("Fail %0t uart_tx idle after frame expected 1 got %b",
                                 $time, uart_tx);
                        error = 1'b1;
                    end
                end
                frames = frames + 1;
            end
        end
    end

endmodule

//--- tb_mmio.sv
// testbench for the load/store and MMIO subsystem
// drives requests, mirrors the RAM in a byte model and checks every load by assertion
`timescale 1ns/1ns

module tb_mmio;

    localparam int win_words = 16;
    localparam int cycle_gap = 7;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    logic                        req_is_store;
    lsu_pkg::access_size_t       req_size;
    logic                        req_unsigned;
    logic [31:0]                 req_addr;
    logic [31:0]                 req_wdata;
    logic [lsu_pkg::gpio_w-1:0]  gpi;
    logic                        rsp_valid;
    logic [31:0]                 rsp_rdata;
    logic [lsu_pkg::gpio_w-1:0]  gpo;
    logic                        uart_tx;

    logic        chk_en;
    logic [31:0] exp_now;
    logic        load_q;
    logic        chk_q;
    logic [31:0] exp_q;
    logic [7:0]  mon_byte;
    int          mon_frames;
    logic        mon_error;
    logic [7:0]  model_mem [0:lsu_pkg::dmem_bytes-1];
    int          seed;

    mmio_top uut (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_is_store(req_is_store),
        .req_size(req_size), .req_unsigned(req_unsigned), .req_addr(req_addr),
        .req_wdata(req_wdata), .gpi(gpi), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
        .gpo(gpo), .uart_tx(uart_tx)
    );

    tb_uart_monitor u_monitor (
        .clk(clk), .uart_tx(uart_tx), .expect_byte(mon_byte),
        .frames(mon_frames), .error(mon_error)
    );

    always #10 clk = ~clk;

    task automatic abort_run;
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // ==============================
    // response checks
    // ==============================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
            chk_q <= 1'b0;
            exp_q <= '0;
        end else begin
            load_q <= req_valid && !req_is_store;
            chk_q <= req_valid && !req_is_store && chk_en;
            exp_q <= exp_now;
        end
    end

    a_rsp_valid: assert property (@(negedge clk) disable iff (!rst_n) rsp_valid == load_q)
    else begin
        $display("Fail %0t rsp_valid expected %b got %b", $time, load_q, rsp_valid);
        abort_run();
    end

    a_rsp_data: assert property (@(negedge clk) disable iff (!rst_n) chk_q |-> rsp_rdata == exp_q)
    else begin
        $display("Fail %0t rsp_rdata expected %h got %h", $time, exp_q, rsp_rdata);
        abort_run();
    end

    always @(posedge mon_error) abort_run();

    // ==============================
    // request tasks and RAM model
    // ==============================
    task automatic drive(input logic is_store, input lsu_pkg::access_size_t size,
                         input logic uns, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic chk, input logic [31:0] exp);
        req_valid = 1'b1;
        req_is_store = is_store;
        req_size = size;
        req_unsigned = uns;
        req_addr = addr;
        req_wdata = wdata;
        chk_en = chk;
        exp_now = exp;
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        req_valid = 1'b0;
        chk_en = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic ram_store(input lsu_pkg::access_size_t size, input logic [31:0] addr,
                             input logic [31:0] wdata);
        int off;
        off = int'(addr - lsu_pkg::dmem_base);
        // low bytes of the data land at the addressed bytes
        for (int i = 0; i < (1 << int'(size)); i++) begin
            model_mem[off + i] = wdata[8*i +: 8];
        end
        drive(1'b1, size, 1'b0, addr, wdata, 1'b0, '0);
    endtask

    function automatic logic [31:0] model_load(input logic [31:0] addr,
                                               input lsu_pkg::access_size_t size,
                                               input logic uns);
        int off;
        int nbytes;
        logic [31:0] value;
        off = int'(addr - lsu_pkg::dmem_base);
        nbytes = 1 << int'(size);
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = model_mem[off + i];
        end
        if (!uns && value[8*nbytes-1]) begin
            for (int i = nbytes; i < 4; i++) begin
                value[8*i +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    task automatic load_read(input logic [31:0] addr, output logic [31:0] value);
        drive(1'b0, lsu_pkg::size_word, 1'b0, addr, '0, 1'b0, '0);
        req_valid = 1'b0;
        @(negedge clk);
        value = rsp_rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_uart_idle;
        logic [31:0] status;
        int tries;
        status = 32'd1;
        tries = 0;
        while (status[0] && tries < 100) begin
            load_read(lsu_pkg::uart_tx_addr, status);
            tries++;
        end
        if (status[0]) begin
            $display("timeout: UART busy flag never cleared");
            abort_run();
        end
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (mon_frames < target && cycles < 400) begin
            @(posedge clk);
            cycles++;
        end
        #2;
        if (mon_frames < target) begin
            $display("timeout: UART frame %0d never finished on the serial line", target);
            abort_run();
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin : stimulus
        logic [31:0]                value;
        logic [31:0]                first;
        logic [31:0]                addr;
        logic [31:0]                win_base;
        lsu_pkg::access_size_t      size;
        logic                       uns;
        logic [7:0]                 tx_byte;
        logic [lsu_pkg::gpio_w-1:0] gpi_val;

        seed = 32'h55a7;
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_is_store = 1'b0;
        req_size = lsu_pkg::size_byte;
        req_unsigned = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        gpi = '0;
        chk_en = 1'b0;
        exp_now = '0;
        mon_byte = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        assert (rsp_valid === 1'b0 && uart_tx === 1'b1 && gpo === '0)
        else begin
            $display("Fail %0t rsp_valid/uart_tx/gpo expected 0/1/0 got %b/%b/%h",
                     $time, rsp_valid, uart_tx, gpo);
            abort_run();
        end
        drive(1'b0, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_tx_addr, '0, 1'b1, 32'd0);

        // fill a window of words, then overwrite parts of it
        win_base = lsu_pkg::dmem_base + (32'($random(seed)) & 32'h0000_0fc0);
        for (int i = 0; i < win_words; i++) begin
            ram_store(lsu_pkg::size_word, win_base + 32'(4 * i), $random(seed));
        end
        for (int i = 0; i < 24; i++) begin
            size = ($random(seed) & 1) ? lsu_pkg::size_half : lsu_pkg::size_byte;
            addr = win_base + (32'($random(seed)) & 32'h3f);
            if (size == lsu_pkg::size_half) addr[0] = 1'b0;
            ram_store(size, addr, $random(seed));
        end
        for (int i = 0; i < 48; i++) begin
            size = lsu_pkg::access_size_t'(2'($unsigned($random(seed)) % 3));
            uns = 1'($random(seed));
            addr = win_base + (32'($random(seed)) & 32'h3f);
            if (size == lsu_pkg::size_half) addr[0] = 1'b0;
            if (size == lsu_pkg::size_word) addr[1:0] = 2'b00;
            drive(1'b0, size, uns, addr, '0, 1'b1, model_load(addr, size, uns));
        end
        drive(1'b0, lsu_pkg::size_word, 1'b0, 32'h0000_2000, '0, 1'b1, 32'd0);

        // gpio, gpo and gpi get different nonzero low bits
        value = $random(seed);
        value[1:0] = 2'b01;
        drive(1'b1, lsu_pkg::size_word, 1'b0, lsu_pkg::gpo_addr, value, 1'b0, '0);
        idle(0);
        assert (gpo === value[lsu_pkg::gpio_w-1:0])
        else begin
            $display("Fail %0t gpo expected %h got %h", $time, value[lsu_pkg::gpio_w-1:0], gpo);
            abort_run();
        end
        drive(1'b0, lsu_pkg::size_word, 1'b0, lsu_pkg::gpo_addr, '0, 1'b1,
              32'(value[lsu_pkg::gpio_w-1:0]));
        // io addresses only decode for word accesses
        drive(1'b0, lsu_pkg::size_half, 1'b0, lsu_pkg::gpo_addr, '0, 1'b1, 32'd0);
        gpi_val = (lsu_pkg::gpio_w)'($random(seed));
        gpi_val[1:0] = 2'b10;
        gpi = gpi_val;
        idle(2);
        drive(1'b0, lsu_pkg::size_word, 1'b0, lsu_pkg::gpi_addr, '0, 1'b1, 32'(gpi_val));
        idle(1);

        // two counter reads cycle_gap cycles apart
        load_read(lsu_pkg::cycle_addr, first);
        idle(cycle_gap - 2);
        load_read(lsu_pkg::cycle_addr, value);
        assert (value - first == 32'(cycle_gap))
        else begin
            $display("Fail %0t cycle_count delta expected %0d got %0d",
                     $time, cycle_gap, value - first);
            abort_run();
        end

        // uart: second store lands while busy and must be dropped
        tx_byte = 8'($random(seed));
        mon_byte = tx_byte;
        drive(1'b1, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_tx_addr, 32'(tx_byte), 1'b0, '0);
        drive(1'b1, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_tx_addr, 32'(~tx_byte), 1'b0, '0);
        drive(1'b0, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_tx_addr, '0, 1'b1, 32'd1);
        idle(1);
        wait_frames(1);
        wait_uart_idle();
        tx_byte = 8'($random(seed));
        mon_byte = tx_byte;
        drive(1'b1, lsu_pkg::size_word, 1'b0, lsu_pkg::uart_tx_addr, 32'(tx_byte), 1'b0, '0);
        idle(1);
        wait_frames(2);

        if (mon_error) begin
            abort_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
lsu_pkg.sv
lsu_request_decode.sv
data_ram.sv
lsu_load_align.sv
io_regs.sv
baud_timer.sv
uart_tx_fsm.sv
mmio_top.sv
tb_uart_monitor.sv
tb_mmio.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator, pass only if the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mmio -f vlog.f -o tb_mmio_sim
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_mmio_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
